// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - files:
      - isa_pkg.sv
      - core_pkg.sv
      - dispatch_unit.sv
      - exec_lane.sv
      - reorder_buffer.sv
      - ooo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ooo_core.sv

// ==== all.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
dispatch_unit.sv
exec_lane.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

// ==== core_pkg.sv ====
// Microarchitecture parameters of the out-of-order core
// Lane count, ROB sizing, multiply latency and counter types
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Execution lanes
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_lanes   = 3;
  localparam int mul_latency = 4;   // Cycles from issue to result strobe

  // Countdown for the multiply, holds mul_latency-1
  typedef logic [$clog2(mul_latency)-1:0] mul_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Reorder buffer
  ////////////////////////////////////////////////////////////////////////////

  localparam int rob_depth = 8;

  typedef logic [$clog2(rob_depth)-1:0] tag_t;       // ROB slot index
  typedef logic [$clog2(rob_depth):0]   rob_cnt_t;   // Occupancy, 0..rob_depth

  // Retired instructions, halt included
  typedef logic [15:0] count_t;

endpackage

`default_nettype wire

// ==== dispatch_unit.sv ====
// Dispatch stage: instruction handshake, register file and busy scoreboard.
// Issues one instruction to the lowest free lane and allocates its ROB slot.
`default_nettype none

module dispatch_unit (
  input  wire                              clock,
  input  wire                              arst_n,
  // Instruction port, four-phase
  input  wire                              inst_req,
  input  isa_pkg::opcode_e                 inst_opcode,
  input  isa_pkg::reg_idx_t                inst_dest,
  input  isa_pkg::reg_idx_t                inst_src_a,
  input  isa_pkg::reg_idx_t                inst_src_b,
  input  isa_pkg::data_t                   inst_imm,
  output logic                             inst_ack,
  // Lane side
  input  wire  [core_pkg::num_lanes-1:0]   lane_free,
  output logic [core_pkg::num_lanes-1:0]   issue,
  output isa_pkg::opcode_e                 issue_opcode,
  output isa_pkg::data_t                   issue_operand_a,
  output isa_pkg::data_t                   issue_operand_b,
  output core_pkg::tag_t                   issue_tag,
  // ROB allocation
  input  wire                              rob_full,
  input  core_pkg::tag_t                   alloc_tag,
  output logic                             alloc,
  output isa_pkg::reg_idx_t                alloc_dest,
  output logic                             alloc_halt,
  // Retire feedback
  input  wire                              commit_valid,
  input  core_pkg::tag_t                   commit_tag,
  input  isa_pkg::reg_idx_t                commit_dest,
  input  isa_pkg::data_t                   commit_data,
  input  wire                              commit_wr_en
);

  isa_pkg::data_t                   regs     [isa_pkg::num_regs];
  core_pkg::tag_t                   pend_tag [isa_pkg::num_regs];
  logic [isa_pkg::num_regs-1:0]     busy;
  logic                             halt_seen;   // Halt sent, stop dispatching
  logic [core_pkg::num_lanes-1:0]   lane_sel;
  logic                             lane_found;
  logic                             uses_srcs;
  logic                             src_stall;
  logic                             dispatch;
  logic                             marks_dest;

  ////////////////////////////////////////////////////////////////////////////
  // Issue decision
  ////////////////////////////////////////////////////////////////////////////

  // Lowest-numbered free lane wins
  always_comb
  begin
    lane_sel   = '0;
    lane_found = 1'b0;
    for (int i = 0; i < core_pkg::num_lanes; i++)
    begin
      if (lane_free[i] && !lane_found)
      begin
        lane_sel[i] = 1'b1;
        lane_found  = 1'b1;
      end
    end
  end

  assign uses_srcs = (inst_opcode != isa_pkg::op_li) && (inst_opcode != isa_pkg::op_halt);
  assign src_stall = uses_srcs && (busy[inst_src_a] || busy[inst_src_b]);

  // Only a fresh request, never one already acknowledged
  assign dispatch = inst_req && !inst_ack && !src_stall && lane_found &&
                    !rob_full && !halt_seen;

  assign marks_dest = (inst_dest != isa_pkg::zero_reg) && (inst_opcode != isa_pkg::op_halt);

  assign issue        = dispatch ? lane_sel : '0;
  assign issue_opcode = inst_opcode;
  assign issue_tag    = alloc_tag;

  assign issue_operand_a = (inst_src_a == isa_pkg::zero_reg) ? '0 : regs[inst_src_a];

  // Immediate rides on operand b for load-immediate
  always_comb
  begin
    if (inst_opcode == isa_pkg::op_li)
      issue_operand_b = inst_imm;
    else if (inst_src_b == isa_pkg::zero_reg)
      issue_operand_b = '0;
    else
      issue_operand_b = regs[inst_src_b];
  end

  assign alloc      = dispatch;
  assign alloc_dest = inst_dest;
  assign alloc_halt = (inst_opcode == isa_pkg::op_halt);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake, register file and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      inst_ack  <= 1'b0;
      halt_seen <= 1'b0;
      busy      <= '0;
      for (int r = 0; r < isa_pkg::num_regs; r++)
      begin
        regs[r]     <= '0;
        pend_tag[r] <= '0;
      end
    end
    else
    begin
      if (dispatch)
        inst_ack <= 1'b1;
      else if (inst_ack && !inst_req)
        inst_ack <= 1'b0;   // Source has let go

      if (dispatch && alloc_halt)
        halt_seen <= 1'b1;

      // Retire first, a same-cycle dispatch to the register overrides busy
      if (commit_valid && commit_wr_en && commit_dest != isa_pkg::zero_reg)
        regs[commit_dest] <= commit_data;
      if (commit_valid && busy[commit_dest] && pend_tag[commit_dest] == commit_tag)
        busy[commit_dest] <= 1'b0;   // Youngest writer has landed

      if (dispatch && marks_dest)
      begin
        busy[inst_dest]     <= 1'b1;
        pend_tag[inst_dest] <= alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== exec_lane.sv ====
// Execution lane: single-cycle ALU ops and a multi-cycle multiply.
// Busy from issue until the result strobe goes out.
`default_nettype none

module exec_lane (
  input  wire                clock,
  input  wire                arst_n,
  input  wire                issue,
  input  isa_pkg::opcode_e   opcode,
  input  isa_pkg::data_t     operand_a,
  input  isa_pkg::data_t     operand_b,
  input  core_pkg::tag_t     tag,
  output logic               lane_free,
  output logic               result_valid,
  output core_pkg::tag_t     result_tag,
  output isa_pkg::data_t     result_data
);

  logic                 busy;
  core_pkg::mul_cnt_t   cnt;    // Cycles left before the strobe
  isa_pkg::opcode_e     op_q;
  isa_pkg::data_t       a_q;
  isa_pkg::data_t       b_q;
  core_pkg::tag_t       tag_q;

  // Control state
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (issue)
    begin
      busy <= 1'b1;
      cnt  <= (opcode == isa_pkg::op_mul) ?
              core_pkg::mul_cnt_t'(core_pkg::mul_latency - 1) : '0;
    end
    else if (result_valid)
      busy <= 1'b0;
    else if (busy)
      cnt <= cnt - 1'b1;
  end

  // Operation latch
  always_ff @(posedge clock)
  begin
    if (issue)
    begin
      op_q  <= opcode;
      a_q   <= operand_a;
      b_q   <= operand_b;
      tag_q <= tag;
    end
  end

  assign lane_free    = !busy;
  assign result_valid = busy && (cnt == '0);
  assign result_tag   = tag_q;

  always_comb
  begin
    case (op_q)
      isa_pkg::op_li:  result_data = b_q;
      isa_pkg::op_add: result_data = a_q + b_q;
      isa_pkg::op_sub: result_data = a_q - b_q;
      isa_pkg::op_and: result_data = a_q & b_q;
      isa_pkg::op_or:  result_data = a_q | b_q;
      isa_pkg::op_xor: result_data = a_q ^ b_q;
      isa_pkg::op_sll: result_data = a_q << b_q[4:0];
      isa_pkg::op_mul: result_data = a_q * b_q;   // Low half only
      default:         result_data = '0;          // Halt carries no value
    endcase
  end

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
// ISA definitions for the out-of-order core
// Opcodes, register file geometry, value width and core status
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int data_width = 32;   // One register value
  localparam int num_regs   = 8;    // Architectural registers

  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
  typedef logic [data_width-1:0]       data_t;

  // Hardwired zero, reads 0 and never takes a write
  localparam reg_idx_t zero_reg = reg_idx_t'(0);

  ////////////////////////////////////////////////////////////////////////////
  // Decoded operations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    op_li,    // Load immediate into dest
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,   // Shift by low 5 bits of b
    op_mul,   // Multi-cycle, low half of product
    op_halt   // Stops dispatch, sets status on retire
  } opcode_e;

  // Core state seen on the commit side
  typedef enum logic {
    status_running,
    status_halted
  } core_status_e;

endpackage

`default_nettype wire

// ==== ooo_core.sv ====
// Out-of-order core top: dispatch feeds identical lanes,
// the reorder buffer drains them in program order.
`default_nettype none

module ooo_core (
  input  wire                     clock,
  input  wire                     arst_n,
  // Instruction port
  input  wire                     inst_req,
  input  isa_pkg::opcode_e        inst_opcode,
  input  isa_pkg::reg_idx_t       inst_dest,
  input  isa_pkg::reg_idx_t       inst_src_a,
  input  isa_pkg::reg_idx_t       inst_src_b,
  input  isa_pkg::data_t          inst_imm,
  output logic                    inst_ack,
  // Commit port
  output logic                    commit_valid,
  output core_pkg::tag_t          commit_tag,
  output isa_pkg::reg_idx_t       commit_dest,
  output isa_pkg::data_t          commit_data,
  output logic                    commit_wr_en,
  output core_pkg::count_t        completed_count,
  output isa_pkg::core_status_e   core_status
);

  logic [core_pkg::num_lanes-1:0]  lane_free;
  logic [core_pkg::num_lanes-1:0]  issue;
  isa_pkg::opcode_e                issue_opcode;
  isa_pkg::data_t                  issue_operand_a;
  isa_pkg::data_t                  issue_operand_b;
  core_pkg::tag_t                  issue_tag;
  logic                            alloc;
  isa_pkg::reg_idx_t               alloc_dest;
  logic                            alloc_halt;
  core_pkg::tag_t                  alloc_tag;
  logic                            rob_full;
  logic [core_pkg::num_lanes-1:0]  result_valid;
  core_pkg::tag_t                  result_tag  [core_pkg::num_lanes];
  isa_pkg::data_t                  result_data [core_pkg::num_lanes];

  dispatch_unit i_dispatch_unit (
    .clock, .arst_n,
    .inst_req, .inst_opcode, .inst_dest, .inst_src_a, .inst_src_b, .inst_imm, .inst_ack,
    .lane_free, .issue, .issue_opcode, .issue_operand_a, .issue_operand_b, .issue_tag,
    .rob_full, .alloc_tag, .alloc, .alloc_dest, .alloc_halt,
    .commit_valid, .commit_tag, .commit_dest, .commit_data, .commit_wr_en
  );

  // Lanes share the issue bus, each has its own strobe
  for (genvar g = 0; g < core_pkg::num_lanes; g++)
  begin : g_lane
    exec_lane i_exec_lane (
      .clock        (clock),
      .arst_n       (arst_n),
      .issue        (issue[g]),
      .opcode       (issue_opcode),
      .operand_a    (issue_operand_a),
      .operand_b    (issue_operand_b),
      .tag          (issue_tag),
      .lane_free    (lane_free[g]),
      .result_valid (result_valid[g]),
      .result_tag   (result_tag[g]),
      .result_data  (result_data[g])
    );
  end

  reorder_buffer i_reorder_buffer (
    .clock, .arst_n,
    .alloc, .alloc_dest, .alloc_halt, .alloc_tag, .rob_full,
    .result_valid, .result_tag, .result_data,
    .commit_valid, .commit_tag, .commit_dest, .commit_data, .commit_wr_en,
    .completed_count, .core_status
  );

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
// Reorder buffer: collects lane results by tag and retires the head in order.
// Drives the commit port, retired-instruction count and halt status.
`default_nettype none

module reorder_buffer (
  input  wire                              clock,
  input  wire                              arst_n,
  // Allocation from dispatch
  input  wire                              alloc,
  input  isa_pkg::reg_idx_t                alloc_dest,
  input  wire                              alloc_halt,
  output core_pkg::tag_t                   alloc_tag,
  output logic                             rob_full,
  // One write port per lane
  input  wire  [core_pkg::num_lanes-1:0]   result_valid,
  input  core_pkg::tag_t                   result_tag  [core_pkg::num_lanes],
  input  isa_pkg::data_t                   result_data [core_pkg::num_lanes],
  // Retire
  output logic                             commit_valid,
  output core_pkg::tag_t                   commit_tag,
  output isa_pkg::reg_idx_t                commit_dest,
  output isa_pkg::data_t                   commit_data,
  output logic                             commit_wr_en,
  output core_pkg::count_t                 completed_count,
  output isa_pkg::core_status_e            core_status
);

  isa_pkg::reg_idx_t                 dest  [core_pkg::rob_depth];
  isa_pkg::data_t                    data  [core_pkg::rob_depth];
  logic [core_pkg::rob_depth-1:0]    halt;
  logic [core_pkg::rob_depth-1:0]    done;
  core_pkg::tag_t                    head;
  core_pkg::tag_t                    tail;
  core_pkg::rob_cnt_t                occupancy;

  assign alloc_tag = tail;
  assign rob_full  = (occupancy == core_pkg::rob_cnt_t'(core_pkg::rob_depth));

  ////////////////////////////////////////////////////////////////////////////
  // Head entry drives the commit port
  ////////////////////////////////////////////////////////////////////////////

  assign commit_valid = (occupancy != '0) && done[head];
  assign commit_tag   = head;
  assign commit_dest  = dest[head];
  assign commit_data  = data[head];
  assign commit_wr_en = commit_valid && !halt[head] && (dest[head] != isa_pkg::zero_reg);

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, done flags, count and status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      head            <= '0;
      tail            <= '0;
      occupancy       <= '0;
      done            <= '0;
      completed_count <= '0;
      core_status     <= isa_pkg::status_running;
    end
    else
    begin
      if (commit_valid)
      begin
        done[head]      <= 1'b0;
        head            <= head + 1'b1;   // Wraps with depth a power of two
        completed_count <= completed_count + 1'b1;
        if (halt[head])
          core_status <= isa_pkg::status_halted;   // Sticky until reset
      end

      if (alloc)
      begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end

      if (alloc && !commit_valid)
        occupancy <= occupancy + 1'b1;
      else if (!alloc && commit_valid)
        occupancy <= occupancy - 1'b1;

      // Several lanes may finish together
      for (int i = 0; i < core_pkg::num_lanes; i++)
      begin
        if (result_valid[i])
          done[result_tag[i]] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clock)
  begin
    if (alloc)
    begin
      dest[tail] <= alloc_dest;
      halt[tail] <= alloc_halt;
    end
    for (int i = 0; i < core_pkg::num_lanes; i++)
    begin
      if (result_valid[i])
        data[result_tag[i]] <= result_data[i];
    end
  end

endmodule

`default_nettype wire

// ==== tb_program.svh ====
// Program for the core testbench, one decoded instruction per entry
// Columns: opcode, dest, src a, src b, imm, then expected commit dest, data, write enable
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
  isa_pkg::opcode_e   op;
  isa_pkg::reg_idx_t  dest;
  isa_pkg::reg_idx_t  src_a;
  isa_pkg::reg_idx_t  src_b;
  isa_pkg::data_t     imm;
  isa_pkg::reg_idx_t  exp_dest;
  isa_pkg::data_t     exp_data;
  logic               exp_wr_en;
} prog_entry_t;

localparam int prog_len = 20;

prog_entry_t prog [prog_len];

function automatic void load_program();
  // Every ALU op on r1 = 5 and r2 = 3
  prog[0]  = '{isa_pkg::op_li,   3'd1, 3'd0, 3'd0, 32'h0000_0005, 3'd1, 32'h0000_0005, 1'b1};
  prog[1]  = '{isa_pkg::op_li,   3'd2, 3'd0, 3'd0, 32'h0000_0003, 3'd2, 32'h0000_0003, 1'b1};
  prog[2]  = '{isa_pkg::op_add,  3'd3, 3'd1, 3'd2, 32'h0, 3'd3, 32'h0000_0008, 1'b1};
  prog[3]  = '{isa_pkg::op_sub,  3'd4, 3'd1, 3'd2, 32'h0, 3'd4, 32'h0000_0002, 1'b1};
  prog[4]  = '{isa_pkg::op_and,  3'd5, 3'd1, 3'd2, 32'h0, 3'd5, 32'h0000_0001, 1'b1};
  prog[5]  = '{isa_pkg::op_or,   3'd6, 3'd1, 3'd2, 32'h0, 3'd6, 32'h0000_0007, 1'b1};
  prog[6]  = '{isa_pkg::op_xor,  3'd7, 3'd1, 3'd2, 32'h0, 3'd7, 32'h0000_0006, 1'b1};
  prog[7]  = '{isa_pkg::op_sll,  3'd3, 3'd1, 3'd2, 32'h0, 3'd3, 32'h0000_0028, 1'b1};
  // Multiply, then independent adds that finish first
  prog[8]  = '{isa_pkg::op_li,   3'd4, 3'd0, 3'd0, 32'h0000_1234, 3'd4, 32'h0000_1234, 1'b1};
  prog[9]  = '{isa_pkg::op_mul,  3'd5, 3'd4, 3'd1, 32'h0, 3'd5, 32'h0000_5b04, 1'b1};
  prog[10] = '{isa_pkg::op_add,  3'd6, 3'd2, 3'd2, 32'h0, 3'd6, 32'h0000_0006, 1'b1};
  prog[11] = '{isa_pkg::op_add,  3'd7, 3'd1, 3'd1, 32'h0, 3'd7, 32'h0000_000a, 1'b1};
  prog[12] = '{isa_pkg::op_add,  3'd3, 3'd5, 3'd2, 32'h0, 3'd3, 32'h0000_5b07, 1'b1};
  // Register 0 takes no write and still reads 0
  prog[13] = '{isa_pkg::op_li,   3'd0, 3'd0, 3'd0, 32'h0000_dead, 3'd0, 32'h0000_dead, 1'b0};
  prog[14] = '{isa_pkg::op_add,  3'd1, 3'd0, 3'd2, 32'h0, 3'd1, 32'h0000_0003, 1'b1};
  // RAW chain through a multiply
  prog[15] = '{isa_pkg::op_xor,  3'd2, 3'd1, 3'd0, 32'h0, 3'd2, 32'h0000_0003, 1'b1};
  prog[16] = '{isa_pkg::op_sub,  3'd4, 3'd0, 3'd2, 32'h0, 3'd4, 32'hffff_fffd, 1'b1};
  prog[17] = '{isa_pkg::op_mul,  3'd6, 3'd4, 3'd4, 32'h0, 3'd6, 32'h0000_0009, 1'b1};
  prog[18] = '{isa_pkg::op_sll,  3'd7, 3'd6, 3'd2, 32'h0, 3'd7, 32'h0000_0048, 1'b1};
  prog[19] = '{isa_pkg::op_halt, 3'd0, 3'd0, 3'd0, 32'h0, 3'd0, 32'h0000_0000, 1'b0};
endfunction

`endif

// ==== tb_ooo_core.sv ====
// Testbench for the out-of-order core
// Feeds a decoded program over the handshake and checks each commit in order
`default_nettype none

module tb_ooo_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          wait_limit  = 200;   // Cycles allowed per wait
  localparam int          halt_window = 40;    // Ack must stay low after halt
  localparam logic [31:0] seed        = 32'h9e43eae4;

  logic                    clock;
  logic                    arst_n;
  logic                    inst_req;
  isa_pkg::opcode_e        inst_opcode;
  isa_pkg::reg_idx_t       inst_dest;
  isa_pkg::reg_idx_t       inst_src_a;
  isa_pkg::reg_idx_t       inst_src_b;
  isa_pkg::data_t          inst_imm;
  logic                    inst_ack;
  logic                    commit_valid;
  core_pkg::tag_t          commit_tag;
  isa_pkg::reg_idx_t       commit_dest;
  isa_pkg::data_t          commit_data;
  logic                    commit_wr_en;
  core_pkg::count_t        completed_count;
  isa_pkg::core_status_e   core_status;

  `include "tb_program.svh"

  ooo_core i_ooo_core (
    .clock, .arst_n,
    .inst_req, .inst_opcode, .inst_dest, .inst_src_a, .inst_src_b, .inst_imm, .inst_ack,
    .commit_valid, .commit_tag, .commit_dest, .commit_data, .commit_wr_en,
    .completed_count, .core_status
  );

  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input isa_pkg::data_t exp,
                            input isa_pkg::data_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input isa_pkg::reg_idx_t exp,
                           input isa_pkg::reg_idx_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected r%0d, actual r%0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_tag(input string name, input core_pkg::tag_t exp,
                           input core_pkg::tag_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected tag %0d, actual tag %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input core_pkg::count_t exp,
                             input core_pkg::count_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input isa_pkg::core_status_e exp,
                              input isa_pkg::core_status_e act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Handshake driver and commit monitor
  ////////////////////////////////////////////////////////////////////////////

  // Samples inst_ack just after each rising edge until it reaches level
  task automatic wait_ack(input logic level, input int limit, output bit seen);
    seen = 1'b0;
    for (int cycles = 0; cycles < limit && !seen; cycles++)
    begin
      @(posedge clock);
      #1;
      seen = (inst_ack === level);
    end
  endtask

  task automatic send_program();
    bit seen;
    int gap;
    @(posedge clock);
    #1;
    for (int n = 0; n < prog_len; n++)
    begin
      gap = $urandom_range(3, 0);
      if (n > 0 && prog[n-1].op == isa_pkg::op_mul)
        gap = 0;   // Next op can overtake the multiply
      repeat (gap)
      begin
        @(posedge clock);
        #1;
      end
      inst_opcode = prog[n].op;
      inst_dest   = prog[n].dest;
      inst_src_a  = prog[n].src_a;
      inst_src_b  = prog[n].src_b;
      inst_imm    = prog[n].imm;
      inst_req    = 1'b1;
      wait_ack(1'b1, wait_limit, seen);
      if (!seen)
      begin
        $display("inst_ack never rose for entry %0d", n);
        stop_run();
      end
      inst_req = 1'b0;
      wait_ack(1'b0, wait_limit, seen);
      if (!seen)
      begin
        $display("inst_ack stayed high after request drop, entry %0d", n);
        stop_run();
      end
    end
  endtask

  task automatic watch_commits();
    int    cycles;
    string name;
    for (int n = 0; n < prog_len; n++)
    begin
      cycles = 0;
      @(negedge clock);
      while (commit_valid !== 1'b1)
      begin
        cycles++;
        if (cycles > wait_limit)
        begin
          $display("no commit for entry %0d within %0d cycles", n, wait_limit);
          stop_run();
        end
        @(negedge clock);
      end
      name = $sformatf("commit %0d", n);
      check_tag(name, core_pkg::tag_t'(n % core_pkg::rob_depth), commit_tag);   // Slots from 0
      check_reg(name, prog[n].exp_dest, commit_dest);
      check_data(name, prog[n].exp_data, commit_data);
      check_flag(name, prog[n].exp_wr_en, commit_wr_en);
      check_count(name, core_pkg::count_t'(n), completed_count);   // Before this retire
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    bit seen;
    clock       = 1'b0;
    arst_n      = 1'b0;
    inst_req    = 1'b0;
    inst_opcode = isa_pkg::op_li;
    inst_dest   = '0;
    inst_src_a  = '0;
    inst_src_b  = '0;
    inst_imm    = '0;
    void'($urandom(seed));
    load_program();

    repeat (5) @(posedge clock);
    #1 arst_n = 1'b1;

    @(negedge clock);
    check_flag("reset inst_ack", 1'b0, inst_ack);
    check_flag("reset commit_valid", 1'b0, commit_valid);
    check_flag("reset commit_wr_en", 1'b0, commit_wr_en);
    check_count("reset count", '0, completed_count);
    check_status("reset status", isa_pkg::status_running, core_status);

    fork
      send_program();
      watch_commits();
    join

    @(negedge clock);   // Halt has retired
    check_status("halt status", isa_pkg::status_halted, core_status);
    check_count("final count", core_pkg::count_t'(prog_len), completed_count);
    check_flag("commit after halt", 1'b0, commit_valid);

    // A request after halt gets no ack
    @(posedge clock);
    #1;
    inst_opcode = isa_pkg::op_add;
    inst_dest   = 3'd1;
    inst_src_a  = 3'd2;
    inst_src_b  = 3'd2;
    inst_req    = 1'b1;
    wait_ack(1'b1, halt_window, seen);
    if (seen)
    begin
      $display("inst_ack rose for a request after halt");
      stop_run();
    end
    @(posedge clock);
    #1 inst_req = 1'b0;

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
